// File: rf_addr_decode.sv
`default_nettype none

module rf_addr_decode
(
    input  wire logic                                  i_clock,
    input  wire logic                                  i_reset,
    input  wire rf_status_pkg::rf_addr_t               rd_addr,
    output rf_status_pkg::rf_region_e                  region,
    output logic [rf_status_pkg::N_LANES-1:0]          lane_hit,
    output rf_status_pkg::global_reg_e                 global_sel,
    output rf_status_pkg::rf_addr_t                    addr_q
);

    logic [rf_status_pkg::NB_GROUP_OFS-1:0] ofs;
    rf_status_pkg::rf_addr_t                grp_base;
    rf_status_pkg::rf_region_e              region_d;
    logic                                   is_lane;
    logic [rf_status_pkg::N_LANES-1:0]      lane_hit_d;

    assign ofs      = rd_addr[rf_status_pkg::NB_GROUP_OFS-1:0];
    assign grp_base = {rd_addr[rf_status_pkg::NB_ADDR-1:rf_status_pkg::NB_GROUP_OFS],
                       {rf_status_pkg::NB_GROUP_OFS{1'b0}}};

    always_comb
    begin
        region_d = rf_status_pkg::REGION_NONE;
        case (grp_base)
            rf_status_pkg::ADDR_GLOBAL_BASE:
            begin
                if (ofs < rf_status_pkg::N_GLOBAL_REGS)
                    region_d = rf_status_pkg::REGION_GLOBAL;
            end
            rf_status_pkg::ADDR_BIP_BASE:
            begin
                if (ofs < rf_status_pkg::N_LANES)
                    region_d = rf_status_pkg::REGION_BIP;
            end
            rf_status_pkg::ADDR_RESYNC_BASE:
            begin
                if (ofs < rf_status_pkg::N_LANES)
                    region_d = rf_status_pkg::REGION_RESYNC;
            end
            rf_status_pkg::ADDR_LANE_ID_BASE:
            begin
                if (ofs < rf_status_pkg::N_LANES)
                    region_d = rf_status_pkg::REGION_LANE_ID;
            end
            default:
            begin
                region_d = rf_status_pkg::REGION_NONE;  // Beyond the map
            end
        endcase
    end

    assign is_lane = (region_d == rf_status_pkg::REGION_BIP)    ||
                     (region_d == rf_status_pkg::REGION_RESYNC) ||
                     (region_d == rf_status_pkg::REGION_LANE_ID);

    // One-hot, only for a mapped lane offset
    always_comb
    begin
        for (int k = 0; k < rf_status_pkg::N_LANES; k++)
        begin
            lane_hit_d[k] = is_lane && (ofs == rf_status_pkg::lane_idx_t'(k));
        end
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
        begin
            region   <= rf_status_pkg::REGION_NONE;
            lane_hit <= '0;
            addr_q   <= '0;
        end
        else
        begin
            region   <= region_d;
            lane_hit <= lane_hit_d;
            addr_q   <= rd_addr;  // Fallback read data
        end
    end

    always_ff @(posedge i_clock)
    begin
        global_sel <= rf_status_pkg::global_reg_e'(ofs[2:0]);
    end

endmodule

`default_nettype wire

// File: rf_lane_status.sv
`default_nettype none

module rf_lane_status
(
    input  wire logic                                      lane_hit,
    input  wire rf_status_pkg::rf_region_e                 region,
    input  wire logic [rf_status_pkg::NB_BIP_ERR-1:0]      bip_error_count,
    input  wire logic [rf_status_pkg::NB_RESYNC_CNT-1:0]   resync_count,
    input  wire rf_status_pkg::lane_idx_t                  lane_id,
    output rf_status_pkg::rf_data_t                        lane_data
);

    rf_status_pkg::rf_data_t field;

    always_comb
    begin
        case (region)
            rf_status_pkg::REGION_BIP:
            begin
                field = rf_status_pkg::rf_data_t'(bip_error_count);
            end
            rf_status_pkg::REGION_RESYNC:
            begin
                field = rf_status_pkg::rf_data_t'(resync_count);
            end
            rf_status_pkg::REGION_LANE_ID:
            begin
                field = rf_status_pkg::rf_data_t'(lane_id);
            end
            default:
            begin
                field = '0;  // Global or unmapped
            end
        endcase
    end

    // Idle lanes drive zero so the merge can OR them
    assign lane_data = lane_hit ? field : '0;

endmodule

`default_nettype wire

// File: rf_read_merge.sv
`default_nettype none

module rf_read_merge
(
    input  wire logic                                              i_clock,
    input  wire logic                                              i_reset,
    input  wire rf_status_pkg::rf_region_e                         region,
    input  wire rf_status_pkg::global_reg_e                        global_sel,
    input  wire rf_status_pkg::rf_addr_t                           addr_q,
    input  wire rf_status_pkg::rf_data_t [rf_status_pkg::N_LANES-1:0] lane_data,
    input  wire logic [rf_status_pkg::N_LANES-1:0]                 block_lock,
    input  wire logic                                              hi_ber,
    input  wire logic [rf_status_pkg::N_LANES-1:0]                 am_lock,
    input  wire logic                                              deskew_done,
    input  wire logic [rf_status_pkg::NB_ERR_CNT-1:0]              decode_error_count,
    input  wire logic [rf_status_pkg::NB_ERR_CNT-1:0]              mismatch_count,
    input  wire logic [rf_status_pkg::NB_ERR_CNT-1:0]              frame_error_count,
    input  wire logic                                              frame_lock,
    output rf_status_pkg::rf_data_t                                rd_data
);

    rf_status_pkg::rf_data_t global_word;
    rf_status_pkg::rf_data_t lane_word;
    rf_status_pkg::rf_data_t rd_data_d;

    always_comb
    begin
        case (global_sel)
            rf_status_pkg::GREG_BLOCK_LOCK:  global_word = rf_status_pkg::rf_data_t'(block_lock);
            rf_status_pkg::GREG_HI_BER:      global_word = rf_status_pkg::rf_data_t'(hi_ber);
            rf_status_pkg::GREG_AM_LOCK:     global_word = rf_status_pkg::rf_data_t'(am_lock);
            rf_status_pkg::GREG_DESKEW_DONE: global_word = rf_status_pkg::rf_data_t'(deskew_done);
            rf_status_pkg::GREG_DECODE_ERR:
                global_word = rf_status_pkg::rf_data_t'(decode_error_count);
            rf_status_pkg::GREG_MISMATCH:
                global_word = rf_status_pkg::rf_data_t'(mismatch_count);
            rf_status_pkg::GREG_FRAME_ERR:
                global_word = rf_status_pkg::rf_data_t'(frame_error_count);
            default:                         global_word = rf_status_pkg::rf_data_t'(frame_lock);
        endcase
    end

    // At most one lane is non-zero
    always_comb
    begin
        lane_word = '0;
        for (int k = 0; k < rf_status_pkg::N_LANES; k++)
        begin
            lane_word = lane_word | lane_data[k];
        end
    end

    always_comb
    begin
        case (region)
            rf_status_pkg::REGION_GLOBAL:  rd_data_d = global_word;
            rf_status_pkg::REGION_BIP,
            rf_status_pkg::REGION_RESYNC,
            rf_status_pkg::REGION_LANE_ID: rd_data_d = lane_word;
            default:                       rd_data_d = rf_status_pkg::rf_data_t'(addr_q);
        endcase
    end

    always_ff @(posedge i_clock)
    begin
        if (i_reset)
            rd_data <= '0;
        else
            rd_data <= rd_data_d;
    end

endmodule

`default_nettype wire

// File: rf_status_pkg.sv
`default_nettype none

package rf_status_pkg;

    localparam int N_LANES       = 20;
    localparam int NB_ADDR       = 9;
    localparam int NB_DATA       = 22;
    localparam int NB_BIP_ERR    = 8;
    localparam int NB_RESYNC_CNT = 8;
    localparam int NB_LANE_ID    = 5;
    localparam int NB_ERR_CNT    = 16;
    localparam int NB_LANE_IDX   = 5;

    // Lane-packed bus widths, lane 0 in the top field
    localparam int NB_BIP_BUS     = N_LANES * NB_BIP_ERR;
    localparam int NB_RESYNC_BUS  = N_LANES * NB_RESYNC_CNT;
    localparam int NB_LANE_ID_BUS = N_LANES * NB_LANE_ID;

    localparam int NB_GROUP_OFS  = 5;  // 32 addresses per group
    localparam int N_GLOBAL_REGS = 8;

    typedef logic [NB_ADDR-1:0]     rf_addr_t;
    typedef logic [NB_DATA-1:0]     rf_data_t;
    typedef logic [NB_LANE_IDX-1:0] lane_idx_t;

    localparam rf_addr_t ADDR_GLOBAL_BASE  = 9'h000;
    localparam rf_addr_t ADDR_BIP_BASE     = 9'h020;
    localparam rf_addr_t ADDR_RESYNC_BASE  = 9'h040;
    localparam rf_addr_t ADDR_LANE_ID_BASE = 9'h060;

    typedef enum logic [2:0]
    {
        REGION_GLOBAL,
        REGION_BIP,
        REGION_RESYNC,
        REGION_LANE_ID,
        REGION_NONE
    } rf_region_e;

    // Offsets within the global group
    typedef enum logic [2:0]
    {
        GREG_BLOCK_LOCK  = 3'd0,
        GREG_HI_BER      = 3'd1,
        GREG_AM_LOCK     = 3'd2,
        GREG_DESKEW_DONE = 3'd3,
        GREG_DECODE_ERR  = 3'd4,
        GREG_MISMATCH    = 3'd5,
        GREG_FRAME_ERR   = 3'd6,
        GREG_FRAME_LOCK  = 3'd7
    } global_reg_e;

endpackage

`default_nettype wire

// File: rf_status_readout.f
rf_status_pkg.sv
rf_addr_decode.sv
rf_lane_status.sv
rf_read_merge.sv
rf_status_readout.sv
rf_status_readout_asserts.sv
rf_status_readout_tb.sv

// File: rf_status_readout.sv
`default_nettype none

module rf_status_readout
(
    input  wire logic                                          i_clock,
    input  wire logic                                          i_reset,
    input  wire rf_status_pkg::rf_addr_t                       rd_addr,
    input  wire logic [rf_status_pkg::N_LANES-1:0]             block_lock,
    input  wire logic                                          hi_ber,
    input  wire logic [rf_status_pkg::N_LANES-1:0]             am_lock,
    input  wire logic                                          deskew_done,
    input  wire logic [rf_status_pkg::NB_ERR_CNT-1:0]          decode_error_count,
    input  wire logic [rf_status_pkg::NB_ERR_CNT-1:0]          mismatch_count,
    input  wire logic [rf_status_pkg::NB_ERR_CNT-1:0]          frame_error_count,
    input  wire logic                                          frame_lock,
    input  wire logic [rf_status_pkg::NB_BIP_BUS-1:0]          bip_error_counts,
    input  wire logic [rf_status_pkg::NB_RESYNC_BUS-1:0]       resync_counts,
    input  wire logic [rf_status_pkg::NB_LANE_ID_BUS-1:0]      lane_ids,
    output rf_status_pkg::rf_data_t                            rd_data
);

    rf_status_pkg::rf_region_e                           region;
    logic [rf_status_pkg::N_LANES-1:0]                   lane_hit;
    rf_status_pkg::global_reg_e                          global_sel;
    rf_status_pkg::rf_addr_t                             addr_q;
    rf_status_pkg::rf_data_t [rf_status_pkg::N_LANES-1:0] lane_data;

    rf_addr_decode rf_addr_decode_i
    (
        .i_clock    (i_clock),
        .i_reset    (i_reset),
        .rd_addr    (rd_addr),
        .region     (region),
        .lane_hit   (lane_hit),
        .global_sel (global_sel),
        .addr_q     (addr_q)
    );

    // Lane k takes the k-th field counted from the top of each bus
    for (genvar k = 0; k < rf_status_pkg::N_LANES; k++)
    begin : gen_lane
        rf_lane_status rf_lane_status_i
        (
            .lane_hit        (lane_hit[k]),
            .region          (region),
            .bip_error_count (bip_error_counts[rf_status_pkg::NB_BIP_BUS - 1 -
                                               k*rf_status_pkg::NB_BIP_ERR -:
                                               rf_status_pkg::NB_BIP_ERR]),
            .resync_count    (resync_counts[rf_status_pkg::NB_RESYNC_BUS - 1 -
                                            k*rf_status_pkg::NB_RESYNC_CNT -:
                                            rf_status_pkg::NB_RESYNC_CNT]),
            .lane_id         (lane_ids[rf_status_pkg::NB_LANE_ID_BUS - 1 -
                                       k*rf_status_pkg::NB_LANE_ID -:
                                       rf_status_pkg::NB_LANE_ID]),
            .lane_data       (lane_data[k])
        );
    end

    rf_read_merge rf_read_merge_i
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .region             (region),
        .global_sel         (global_sel),
        .addr_q             (addr_q),
        .lane_data          (lane_data),
        .block_lock         (block_lock),
        .hi_ber             (hi_ber),
        .am_lock            (am_lock),
        .deskew_done        (deskew_done),
        .decode_error_count (decode_error_count),
        .mismatch_count     (mismatch_count),
        .frame_error_count  (frame_error_count),
        .frame_lock         (frame_lock),
        .rd_data            (rd_data)
    );

endmodule

`default_nettype wire

// File: rf_status_readout_asserts.sv
`default_nettype none

module rf_status_readout_asserts
(
    input wire logic                        i_clock,
    input wire logic                        i_reset,
    input wire rf_status_pkg::rf_region_e   region,
    input wire rf_status_pkg::rf_data_t     rd_data
);

    reset_clears_data: assert property (@(posedge i_clock) i_reset |=> rd_data == '0)
        else $error("rd_data not cleared in the cycle after reset");

    data_known: assert property (@(posedge i_clock) disable iff (i_reset)
                                 !$isunknown(rd_data))
        else $error("rd_data has unknown bits outside reset");

    // Lane ID reads only fill the low field
    lane_id_narrow: assert property (@(posedge i_clock) disable iff (i_reset)
        region == rf_status_pkg::REGION_LANE_ID |=>
        rd_data[rf_status_pkg::NB_DATA-1:rf_status_pkg::NB_LANE_ID] == '0)
        else $error("Lane ID read has bits set above the ID width");

endmodule

bind rf_read_merge rf_status_readout_asserts rf_status_readout_asserts_i
(
    .i_clock (i_clock),
    .i_reset (i_reset),
    .region  (region),
    .rd_data (rd_data)
);

`default_nettype wire

// File: rf_status_readout_tb.sv
`default_nettype none

module rf_status_readout_tb;

    localparam int          CLK_HALF       = 50;
    localparam int          DRIVE_DLY      = 10;
    localparam int          RESET_CYCLES   = 3;
    localparam int          GROUP_SPAN     = 32;
    localparam int          B2B_READS      = 400;
    localparam int          TIMEOUT_CYCLES = 2000;  // About 4x the total test length
    localparam logic [31:0] RAND_SEED      = 32'hd527_d062;

    logic                                          i_clock;
    logic                                          i_reset;
    rf_status_pkg::rf_addr_t                       rd_addr;
    logic [rf_status_pkg::N_LANES-1:0]             block_lock;
    logic                                          hi_ber;
    logic [rf_status_pkg::N_LANES-1:0]             am_lock;
    logic                                          deskew_done;
    logic [rf_status_pkg::NB_ERR_CNT-1:0]          decode_error_count;
    logic [rf_status_pkg::NB_ERR_CNT-1:0]          mismatch_count;
    logic [rf_status_pkg::NB_ERR_CNT-1:0]          frame_error_count;
    logic                                          frame_lock;
    logic [rf_status_pkg::NB_BIP_BUS-1:0]          bip_error_counts;
    logic [rf_status_pkg::NB_RESYNC_BUS-1:0]       resync_counts;
    logic [rf_status_pkg::NB_LANE_ID_BUS-1:0]      lane_ids;
    rf_status_pkg::rf_data_t                       rd_data;

    int                      cycle_count = 0;
    int                      check_count = 0;
    int                      error_count = 0;
    int unsigned             seed_dummy;
    rf_status_pkg::rf_data_t exp_p1;  // Expected data one and two cycles in flight
    rf_status_pkg::rf_data_t exp_p2;
    rf_status_pkg::rf_addr_t addr_p1;
    rf_status_pkg::rf_addr_t addr_p2;
    logic                    vld_p1;
    logic                    vld_p2;

    rf_status_readout rf_status_readout_i
    (
        .i_clock            (i_clock),
        .i_reset            (i_reset),
        .rd_addr            (rd_addr),
        .block_lock         (block_lock),
        .hi_ber             (hi_ber),
        .am_lock            (am_lock),
        .deskew_done        (deskew_done),
        .decode_error_count (decode_error_count),
        .mismatch_count     (mismatch_count),
        .frame_error_count  (frame_error_count),
        .frame_lock         (frame_lock),
        .bip_error_counts   (bip_error_counts),
        .resync_counts      (resync_counts),
        .lane_ids           (lane_ids),
        .rd_data            (rd_data)
    );

    always #CLK_HALF i_clock = ~i_clock;

    always @(posedge i_clock)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // Address map lookup with lane 0 in the top field
    function automatic rf_status_pkg::rf_data_t model_read(input rf_status_pkg::rf_addr_t addr);
        int                      ofs;
        int                      base;
        int                      top_k;
        rf_status_pkg::rf_data_t word;
        ofs   = int'(addr) % GROUP_SPAN;
        base  = int'(addr) - ofs;
        top_k = rf_status_pkg::N_LANES - 1 - ofs;
        word  = rf_status_pkg::rf_data_t'(addr);  // Unmapped reads back the address
        if (base == int'(rf_status_pkg::ADDR_GLOBAL_BASE) && ofs < 8)
        begin
            case (ofs)
                0: word = rf_status_pkg::rf_data_t'(block_lock);
                1: word = rf_status_pkg::rf_data_t'(hi_ber);
                2: word = rf_status_pkg::rf_data_t'(am_lock);
                3: word = rf_status_pkg::rf_data_t'(deskew_done);
                4: word = rf_status_pkg::rf_data_t'(decode_error_count);
                5: word = rf_status_pkg::rf_data_t'(mismatch_count);
                6: word = rf_status_pkg::rf_data_t'(frame_error_count);
                default: word = rf_status_pkg::rf_data_t'(frame_lock);
            endcase
        end
        else if (ofs < rf_status_pkg::N_LANES)
        begin
            if (base == int'(rf_status_pkg::ADDR_BIP_BASE))
                word = rf_status_pkg::rf_data_t'(bip_error_counts[top_k*8 +: 8]);
            else if (base == int'(rf_status_pkg::ADDR_RESYNC_BASE))
                word = rf_status_pkg::rf_data_t'(resync_counts[top_k*8 +: 8]);
            else if (base == int'(rf_status_pkg::ADDR_LANE_ID_BASE))
                word = rf_status_pkg::rf_data_t'(lane_ids[top_k*5 +: 5]);
        end
        return word;
    endfunction

    task automatic randomize_status();
        logic [31:0] r;
        r = $urandom;
        block_lock = r[rf_status_pkg::N_LANES-1:0];
        r = $urandom;
        am_lock = r[rf_status_pkg::N_LANES-1:0];
        r = $urandom;
        hi_ber      = r[0];
        deskew_done = r[1];
        frame_lock  = r[2];
        decode_error_count = r[31:16];
        r = $urandom;
        mismatch_count    = r[15:0];
        frame_error_count = r[31:16];
        for (int k = 0; k < rf_status_pkg::N_LANES; k++)
        begin
            r = $urandom;
            bip_error_counts[k*8 +: 8] = r[7:0];
            resync_counts[k*8 +: 8]    = r[15:8];
            lane_ids[k*5 +: 5]         = r[20:16];
        end
    endtask

    task automatic compare_data(input rf_status_pkg::rf_addr_t addr,
                                input rf_status_pkg::rf_data_t expected);
        check_count++;
        if (rd_data !== expected)
        begin
            error_count++;
            $display("FAILED t=%0t rd_data (addr 0x%03h) expected=0x%06h actual=0x%06h",
                     $time, addr, expected, rd_data);
        end
    endtask

    task automatic check_cleared();
        check_count++;
        if (rd_data !== '0)
        begin
            error_count++;
            $display("FAILED t=%0t rd_data expected=0x000000 actual=0x%06h", $time, rd_data);
        end
    endtask

    task automatic advance();
        @(posedge i_clock);
        #DRIVE_DLY;
    endtask

    // Checks the read issued two cycles ago, then drives the new address
    task automatic issue(input rf_status_pkg::rf_addr_t addr, input logic vld);
        if (vld_p2)
            compare_data(addr_p2, exp_p2);
        exp_p2  = exp_p1;
        addr_p2 = addr_p1;
        vld_p2  = vld_p1;
        exp_p1  = model_read(addr);
        addr_p1 = addr;
        vld_p1  = vld;
        rd_addr = addr;
    endtask

    task automatic step(input rf_status_pkg::rf_addr_t addr, input logic vld);
        advance();
        issue(addr, vld);
    endtask

    task automatic drain();
        repeat (2) step('0, 1'b0);
    endtask

    task automatic report_test(input string name, input int errs_before);
        $display("Test %s finished with %0d errors", name, error_count - errs_before);
    endtask

    task automatic test_reset();
        int errs_before;
        errs_before = error_count;
        randomize_status();
        i_reset = 1'b1;
        vld_p1  = 1'b0;
        vld_p2  = 1'b0;
        repeat (RESET_CYCLES) advance();
        i_reset = 1'b0;
        check_cleared();
        issue(rf_status_pkg::rf_addr_t'(rf_status_pkg::ADDR_GLOBAL_BASE + 4), 1'b1);
        step(rf_status_pkg::ADDR_BIP_BASE, 1'b1);
        drain();
        // Unmapped read keeps non-zero data in the pipe when reset hits
        step(9'h1FF, 1'b0);
        step(9'h1FF, 1'b0);
        i_reset = 1'b1;
        advance();
        check_cleared();
        repeat (RESET_CYCLES - 1) advance();
        i_reset = 1'b0;
        report_test("reset", errs_before);
    endtask

    task automatic test_globals();
        int errs_before;
        errs_before = error_count;
        randomize_status();
        for (int g = 0; g < 8; g++)
            step(rf_status_pkg::rf_addr_t'(rf_status_pkg::ADDR_GLOBAL_BASE + g), 1'b1);
        drain();
        report_test("globals", errs_before);
    endtask

    task automatic test_lane_fields();
        int errs_before;
        errs_before = error_count;
        randomize_status();
        for (int k = 0; k < rf_status_pkg::N_LANES; k++)
        begin
            step(rf_status_pkg::rf_addr_t'(rf_status_pkg::ADDR_BIP_BASE + k), 1'b1);
            step(rf_status_pkg::rf_addr_t'(rf_status_pkg::ADDR_RESYNC_BASE + k), 1'b1);
            step(rf_status_pkg::rf_addr_t'(rf_status_pkg::ADDR_LANE_ID_BASE + k), 1'b1);
        end
        drain();
        report_test("lane_fields", errs_before);
    endtask

    task automatic test_unmapped();
        int                      errs_before;
        rf_status_pkg::rf_addr_t holes [10];
        errs_before = error_count;
        holes = '{9'h008, 9'h01F, 9'h034, 9'h03F, 9'h054,
                  9'h05F, 9'h074, 9'h07F, 9'h080, 9'h1FF};  // Lane offsets 20 and 31
        for (int i = 0; i < 10; i++)
            step(holes[i], 1'b1);
        drain();
        report_test("unmapped", errs_before);
    endtask

    task automatic test_back_to_back();
        int                      errs_before;
        int unsigned             pick;
        rf_status_pkg::rf_addr_t addr;
        errs_before = error_count;
        randomize_status();
        for (int n = 0; n < B2B_READS; n++)
        begin
            pick = $urandom % 4;
            if (pick == 0)
                addr = rf_status_pkg::rf_addr_t'($urandom % 512);  // Anywhere
            else if (pick == 1)
                addr = rf_status_pkg::rf_addr_t'($urandom % 8);
            else
                addr = rf_status_pkg::rf_addr_t'(GROUP_SPAN * (1 + $urandom % 3) +
                                                 $urandom % 20);
            step(addr, 1'b1);
        end
        drain();
        report_test("back_to_back", errs_before);
    endtask

    initial
    begin
        seed_dummy         = $urandom(RAND_SEED);
        i_clock            = 1'b0;
        i_reset            = 1'b1;
        rd_addr            = '0;
        block_lock         = '0;
        hi_ber             = 1'b0;
        am_lock            = '0;
        deskew_done        = 1'b0;
        decode_error_count = '0;
        mismatch_count     = '0;
        frame_error_count  = '0;
        frame_lock         = 1'b0;
        bip_error_counts   = '0;
        resync_counts      = '0;
        lane_ids           = '0;
        exp_p1             = '0;
        exp_p2             = '0;
        addr_p1            = '0;
        addr_p2            = '0;
        vld_p1             = 1'b0;
        vld_p2             = 1'b0;
        test_reset();
        test_globals();
        test_lane_fields();
        test_unmapped();
        test_back_to_back();
        $display("Checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --assert -Wno-fatal --top-module rf_status_readout_tb \
    -f rf_status_readout.f > build.log 2>&1 &&
./obj_dir/Vrf_status_readout_tb > sim.log 2>&1

cat build.log sim.log 2>/dev/null
grep -q "STATUS: FAIL" sim.log && exit 1
grep -q "STATUS: PASS" sim.log || exit 1
exit 0
